//--- sources.f
verilog/qeciphy_pkg.sv
verilog/qeciphy_rx_frame_ctrl.sv
verilog/qeciphy_crc_engine.sv
verilog/qeciphy_crc_check.sv
verilog/qeciphy_rx_top.sv
verification/qeciphy_crc_check_assertions.sv
verification/qeciphy_rx_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the receive frame checker testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f \
   --top-module qeciphy_rx_tb --Mdir obj_dir -o qeciphy_rx_sim

./obj_dir/qeciphy_rx_sim | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
   echo "Simulation passed"
   exit 0
else
   echo "Simulation failed"
   exit 1
fi

//--- verification/qeciphy_rx_tb.sv
// ----------------------------------------
// Directed tests; once locked the stream
// never pauses, frames follow back to back
// ----------------------------------------
`timescale 1ns/1ns
`default_nettype none

module qeciphy_rx_tb;

   import qeciphy_pkg::*;

   logic              clk;
   logic              rst_n;
   logic [WORD_W-1:0] tdata;
   logic [WORD_W-1:0] rx_data;
   logic              rx_data_valid;
   logic              locked;
   logic              crc_error;
   logic              check_done;
   integer            seed;
   int                errors;
   int                cycles;
   logic [WORD_W-1:0] frame [FRAME_LEN];
   logic [WORD_W-1:0] got_data_q [$];
   logic [WORD_W-1:0] exp_data_q [$];
   logic              got_err_q [$];
   logic              exp_err_q [$];

   qeciphy_rx_top dut_i (
      .clk_i           (clk),
      .rst_n_i         (rst_n),
      .tdata_i         (tdata),
      .rx_data_o       (rx_data),
      .rx_data_valid_o (rx_data_valid),
      .locked_o        (locked),
      .crc_error_o     (crc_error),
      .check_done_o    (check_done)
   );

   always #2 clk = ~clk;

   // Result monitors and run limit, 20 frames plus margin
   always @(posedge clk) begin
      cycles++;
      if (rst_n && check_done)
         got_err_q.push_back(crc_error);
      if (rst_n && rx_data_valid)
         got_data_q.push_back(rx_data);
      if (cycles > 20 * FRAME_LEN + 200) begin
         $display("Timeout after %0d cycles, the run did not complete", cycles);
         $display("SOME TESTS FAILED");
         $finish;
      end
   end

   task automatic check(input string name, input logic [63:0] got,
                        input logic [63:0] expected);
      if (got !== expected) begin
         errors++;
         $display("error %s expected %h got %h", name, expected, got);
      end
   endtask

   task automatic drive(input logic [WORD_W-1:0] word);
      @(posedge clk);
      #1 tdata = word;
   endtask

   // Bitwise CRC, MSB first, width 8 or 16
   function automatic logic [15:0] ref_crc(input logic [127:0] bits, input int nbits,
                                           input int width, input logic [15:0] poly,
                                           input logic [15:0] init);
      logic [15:0] crc;
      logic [15:0] mask;
      crc  = init;
      mask = 16'hFFFF >> (16 - width);
      for (int i = nbits - 1; i >= 0; i--) begin
         if (crc[width-1] ^ bits[i])
            crc = ((crc << 1) ^ poly) & mask;
         else
            crc = (crc << 1) & mask;
      end
      return crc;
   endfunction

   task automatic build_frame(input bit bad_faw, input bit counting);
      logic [15:0] c [3];
      logic [15:0] vw;
      int          b;
      frame[0] = bad_faw ? ~FAW_PATTERN : FAW_PATTERN;
      for (int g = 0; g < GROUPS_PER_FRAME; g++) begin
         b = 1 + g * GROUP_LEN;
         for (int w = 0; w < GROUP_LEN - 1; w++)
            frame[b+w] = counting ? {32'hC0DE_0000, 32'(b + w)} : {$random(seed), $random(seed)};
         for (int p = 0; p < 3; p++)
            c[p] = ref_crc({frame[b+2*p], frame[b+2*p+1]}, 128, 16, CRC16_POLY, CRC16_INIT);
         vw = ref_crc({80'h0, c[0], c[1], c[2]}, 48, 8, {8'h00, CRC8_POLY}, {8'h00, CRC8_INIT});
         frame[b+GROUP_LEN-1] = {c[0], c[1], c[2], vw[7:0], 8'h00};
      end
   endtask

   // Bit g of bad_groups marks group g as expected to fail its check
   task automatic send_frame(input bit expect_out, input logic [8:0] bad_groups);
      for (int s = 0; s < FRAME_LEN; s++) begin
         drive(frame[s]);
         if (expect_out && (s % GROUP_LEN) != 0)
            exp_data_q.push_back(frame[s]);
      end
      if (expect_out)
         for (int g = 0; g < GROUPS_PER_FRAME; g++)
            exp_err_q.push_back(bad_groups[g]);
   endtask

   task automatic compare_results();
      while (got_err_q.size() != 0 && exp_err_q.size() != 0)
         check("crc_error_o", 64'(got_err_q.pop_front()), 64'(exp_err_q.pop_front()));
      while (got_data_q.size() != 0 && exp_data_q.size() != 0)
         check("rx_data_o", got_data_q.pop_front(), exp_data_q.pop_front());
   endtask

   task automatic lock_test();
      repeat (5) drive({$random(seed), $random(seed)});
      check("locked_o", 64'(locked), 64'h0);
      check("check_done_o count", 64'(got_err_q.size()), 64'h0);
      build_frame(1'b0, 1'b0);
      send_frame(1'b1, 9'h000);
      check("locked_o", 64'(locked), 64'h1);
      compare_results();
   endtask

   task automatic clean_test();
      repeat (3) begin
         build_frame(1'b0, 1'b0);
         send_frame(1'b1, 9'h000);
      end
      compare_results();
   endtask

   task automatic pass_through_test();
      build_frame(1'b0, 1'b1);
      send_frame(1'b1, 9'h000);
      compare_results();
   endtask

   // CRC words of groups 2, 5 and 8 sit in slots 21, 42 and 63
   task automatic crc_error_test();
      build_frame(1'b0, 1'b0);
      frame[3*GROUP_LEN][50] = ~frame[3*GROUP_LEN][50];
      frame[6*GROUP_LEN][20] = ~frame[6*GROUP_LEN][20];
      frame[9*GROUP_LEN][12] = ~frame[9*GROUP_LEN][12];
      send_frame(1'b1, 9'h124);
      compare_results();
   endtask

   // Slot 26 is data word 4 of group 3
   task automatic data_error_test();
      build_frame(1'b0, 1'b0);
      frame[26][33] = ~frame[26][33];
      send_frame(1'b1, 9'h008);
      compare_results();
   endtask

   task automatic lock_loss_test();
      build_frame(1'b1, 1'b0);
      send_frame(1'b1, 9'h000);
      build_frame(1'b1, 1'b0);
      send_frame(1'b0, 9'h000);
      check("locked_o", 64'(locked), 64'h0);
      build_frame(1'b0, 1'b0);
      send_frame(1'b1, 9'h000);
      check("locked_o", 64'(locked), 64'h1);
      compare_results();
   endtask

   // Keep words flowing until the last group check is out
   task automatic drain_pipeline();
      drive(FAW_PATTERN);
      while (exp_err_q.size() != 0 || exp_data_q.size() != 0) begin
         @(posedge clk);
         #1;
         compare_results();
         if (exp_err_q.size() != 0) begin
            tdata = {$random(seed), $random(seed)};
            exp_data_q.push_back(tdata);
         end
      end
      check("check_done_o count", 64'(got_err_q.size()), 64'h0);
      check("rx_data_o count", 64'(got_data_q.size()), 64'h0);
   endtask

   initial begin
      seed   = 35077;
      errors = 0;
      cycles = 0;
      clk    = 1'b0;
      rst_n  = 1'b0;
      tdata  = '0;
      repeat (2) @(posedge clk);
      #1 rst_n = 1'b1;
      lock_test();
      clean_test();
      pass_through_test();
      crc_error_test();
      data_error_test();
      lock_loss_test();
      drain_pipeline();
      $display("Run complete with %0d errors", errors);
      if (errors == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

//--- verification/qeciphy_crc_check_assertions.sv
// ----------------------------------------
// Bound to every qeciphy_crc_check instance
// ----------------------------------------
`timescale 1ns/1ns
`default_nettype none

module qeciphy_crc_check_assertions (
   input logic clk_i,
   input logic rst_n_i,
   input logic faw_boundary_i,
   input logic crc_boundary_i,
   input logic crc_valid_i,
   input logic crc_error_i,
   input logic check_done_i
);

   logic [5:0] frame_pos;
   logic       in_frame;

   // Slot of the current cycle inside the frame opened by the last FAW
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         frame_pos <= '0;
         in_frame  <= 1'b0;
      end else if (faw_boundary_i) begin
         frame_pos <= 6'd1;
         in_frame  <= 1'b1;
      end else begin
         frame_pos <= frame_pos + 6'd1;
         in_frame  <= in_frame && (frame_pos != 6'd63);
      end
   end

   frame_layout: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      in_frame |-> !faw_boundary_i && (crc_boundary_i == ((frame_pos % 6'd7) == 6'd0)))
      else $error("Boundary out of place at frame slot %0d", frame_pos);

   no_stray_boundary: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !in_frame |-> !crc_boundary_i)
      else $error("CRC boundary outside a frame");

   valid_timing: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      crc_valid_i == $past(crc_boundary_i))
      else $error("crc_valid_i not one cycle after crc_boundary_i");

   done_timing: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      check_done_i == $past(crc_valid_i))
      else $error("check_done_o not one cycle after crc_valid_i");

endmodule

bind qeciphy_crc_check qeciphy_crc_check_assertions crc_check_sva_i (
   .clk_i          (clk_i),
   .rst_n_i        (rst_n_i),
   .faw_boundary_i (faw_boundary_i),
   .crc_boundary_i (crc_boundary_i),
   .crc_valid_i    (crc_valid_i),
   .crc_error_i    (crc_error_o),
   .check_done_i   (check_done_o)
);

`default_nettype wire

//--- verilog/qeciphy_rx_top.sv
// ----------------------------------------
// Receive frame checker, no flow control
// Input must carry one word every cycle
// ----------------------------------------
`timescale 1ns/1ns
`default_nettype none

module qeciphy_rx_top (
   input  logic                          clk_i,
   input  logic                          rst_n_i,
   input  logic [qeciphy_pkg::WORD_W-1:0] tdata_i,
   output logic [qeciphy_pkg::WORD_W-1:0] rx_data_o,
   output logic                          rx_data_valid_o,
   output logic                          locked_o,
   output logic                          crc_error_o,
   output logic                          check_done_o
);

   logic        faw_boundary;
   logic        crc_boundary;
   logic [2:0]  group_pos;
   logic [15:0] crc01;
   logic [15:0] crc23;
   logic [15:0] crc45;
   logic [7:0]  crcvw;
   logic        crc_valid;

   // Registered word doubles as the payload output
   qeciphy_rx_frame_ctrl frame_ctrl_i (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .tdata_i        (tdata_i),
      .tdata_o        (rx_data_o),
      .faw_boundary_o (faw_boundary),
      .crc_boundary_o (crc_boundary),
      .data_strobe_o  (rx_data_valid_o),
      .group_pos_o    (group_pos),
      .locked_o       (locked_o)
   );

   qeciphy_crc_engine crc_engine_i (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .tdata_i        (rx_data_o),
      .data_strobe_i  (rx_data_valid_o),
      .crc_boundary_i (crc_boundary),
      .group_pos_i    (group_pos),
      .crc01_o        (crc01),
      .crc23_o        (crc23),
      .crc45_o        (crc45),
      .crcvw_o        (crcvw),
      .crc_valid_o    (crc_valid)
   );

   qeciphy_crc_check crc_check_i (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .faw_boundary_i (faw_boundary),
      .crc_boundary_i (crc_boundary),
      .tdata_i        (rx_data_o),
      .crc01_i        (crc01),
      .crc23_i        (crc23),
      .crc45_i        (crc45),
      .crcvw_i        (crcvw),
      .crc_valid_i    (crc_valid),
      .crc_error_o    (crc_error_o),
      .check_done_o   (check_done_o)
   );

endmodule

`default_nettype wire

//--- verilog/qeciphy_crc_check.sv
// ----------------------------------------
// Expects crc_valid_i one cycle after each
// crc_boundary_i; bits 7..0 are ignored
// ----------------------------------------
`timescale 1ns/1ns
`default_nettype none

module qeciphy_crc_check (
   input  logic        clk_i,
   input  logic        rst_n_i,
   input  logic        faw_boundary_i,
   input  logic        crc_boundary_i,
   input  logic [63:0] tdata_i,
   input  logic [15:0] crc01_i,
   input  logic [15:0] crc23_i,
   input  logic [15:0] crc45_i,
   input  logic [7:0]  crcvw_i,
   input  logic        crc_valid_i,
   output logic        crc_error_o,
   output logic        check_done_o
);

   logic [15:0] rx_crc01;
   logic [15:0] rx_crc23;
   logic [15:0] rx_crc45;
   logic [7:0]  rx_crcvw;
   logic        pending;
   logic        mismatch;

   assign mismatch = (rx_crc01 != crc01_i) || (rx_crc23 != crc23_i) ||
                     (rx_crc45 != crc45_i) || (rx_crcvw != crcvw_i);

   // Received CRC word fields
   always_ff @(posedge clk_i) begin
      if (crc_boundary_i) begin
         rx_crc01 <= tdata_i[63:48];
         rx_crc23 <= tdata_i[47:32];
         rx_crc45 <= tdata_i[31:16];
         rx_crcvw <= tdata_i[15:8];
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         pending      <= 1'b0;
         check_done_o <= 1'b0;
         crc_error_o  <= 1'b0;
      end else begin
         // Group 9 result lands on the FAW cycle and still reads pending
         check_done_o <= crc_valid_i && pending;
         crc_error_o  <= crc_valid_i && pending && mismatch;
         if (crc_boundary_i) begin
            pending <= 1'b1;
         end else if (crc_valid_i || faw_boundary_i) begin
            pending <= 1'b0;
         end
      end
   end

endmodule

`default_nettype wire

//--- verilog/qeciphy_crc_engine.sv
// ----------------------------------------
// Per-group CRC accumulation, 64 bits/cycle
// Results held from each crc_valid_o pulse
// ----------------------------------------
`timescale 1ns/1ns
`default_nettype none

module qeciphy_crc_engine (
   input  logic                          clk_i,
   input  logic                          rst_n_i,
   input  logic [qeciphy_pkg::WORD_W-1:0] tdata_i,
   input  logic                          data_strobe_i,
   input  logic                          crc_boundary_i,
   input  logic [2:0]                    group_pos_i,
   output logic [15:0]                   crc01_o,
   output logic [15:0]                   crc23_o,
   output logic [15:0]                   crc45_o,
   output logic [7:0]                    crcvw_o,
   output logic                          crc_valid_o
);

   import qeciphy_pkg::*;

   logic [15:0] acc01;
   logic [15:0] acc23;
   logic [15:0] acc45;

   // Serial CRC-16 unrolled over one word, MSB first
   function automatic logic [15:0] crc16_next(input logic [15:0]       crc_in,
                                               input logic [WORD_W-1:0] data);
      logic [15:0] crc;
      logic        fb;
      crc = crc_in;
      for (int i = WORD_W - 1; i >= 0; i--) begin
         fb  = crc[15] ^ data[i];
         crc = {crc[14:0], 1'b0};
         if (fb) begin
            crc = crc ^ CRC16_POLY;
         end
      end
      return crc;
   endfunction

   // CRC-8 over the concatenated CRC-16 values
   function automatic logic [7:0] crc8_over(input logic [47:0] data);
      logic [7:0] crc;
      logic       fb;
      crc = CRC8_INIT;
      for (int i = 47; i >= 0; i--) begin
         fb  = crc[7] ^ data[i];
         crc = {crc[6:0], 1'b0};
         if (fb) begin
            crc = crc ^ CRC8_POLY;
         end
      end
      return crc;
   endfunction

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         acc01       <= CRC16_INIT;
         acc23       <= CRC16_INIT;
         acc45       <= CRC16_INIT;
         crc_valid_o <= 1'b0;
      end else begin
         crc_valid_o <= crc_boundary_i;
         if (crc_boundary_i) begin
            acc01 <= CRC16_INIT;
            acc23 <= CRC16_INIT;
            acc45 <= CRC16_INIT;
         end else if (data_strobe_i) begin
            // Words 0..5 feed the three pair accumulators
            case (group_pos_i)
               3'd0, 3'd1: acc01 <= crc16_next(acc01, tdata_i);
               3'd2, 3'd3: acc23 <= crc16_next(acc23, tdata_i);
               3'd4, 3'd5: acc45 <= crc16_next(acc45, tdata_i);
               default:    ;
            endcase
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (crc_boundary_i) begin
         crc01_o <= acc01;
         crc23_o <= acc23;
         crc45_o <= acc45;
         crcvw_o <= crc8_over({acc01, acc23, acc45});
      end
   end

endmodule

`default_nettype wire

//--- verilog/qeciphy_rx_frame_ctrl.sv
// ----------------------------------------
// Frame alignment. Words arrive every cycle
// and all strobes line up with tdata_o
// ----------------------------------------
`timescale 1ns/1ns
`default_nettype none

module qeciphy_rx_frame_ctrl (
   input  logic                          clk_i,
   input  logic                          rst_n_i,
   input  logic [qeciphy_pkg::WORD_W-1:0] tdata_i,
   output logic [qeciphy_pkg::WORD_W-1:0] tdata_o,
   output logic                          faw_boundary_o,
   output logic                          crc_boundary_o,
   output logic                          data_strobe_o,
   output logic [2:0]                    group_pos_o,
   output logic                          locked_o
);

   import qeciphy_pkg::*;

   lock_state_t                    state;
   logic [$clog2(FRAME_LEN)-1:0]   slot_cnt;
   logic [2:0]                     grp_cnt;
   logic [1:0]                     miss_cnt;
   logic                           drop_q;
   logic                           faw_match;

   assign faw_match = (tdata_i == FAW_PATTERN);

   // locked_o stays high for the cycle that holds the dropping slot 0 word
   assign locked_o = (state == LOCKED);

   always_ff @(posedge clk_i) begin
      tdata_o <= tdata_i;
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state          <= HUNT;
         slot_cnt       <= '0;
         grp_cnt        <= '0;
         miss_cnt       <= '0;
         drop_q         <= 1'b0;
         faw_boundary_o <= 1'b0;
         crc_boundary_o <= 1'b0;
         data_strobe_o  <= 1'b0;
         group_pos_o    <= '0;
      end else begin
         faw_boundary_o <= 1'b0;
         crc_boundary_o <= 1'b0;
         data_strobe_o  <= 1'b0;
         drop_q         <= 1'b0;

         if (state == HUNT || drop_q) begin
            // Search every word; the word after a match is slot 1
            if (faw_match) begin
               state          <= LOCKED;
               faw_boundary_o <= 1'b1;
               slot_cnt       <= 1;
               grp_cnt        <= '0;
               miss_cnt       <= '0;
            end else begin
               state <= HUNT;
            end
         end else begin
            slot_cnt <= (slot_cnt == ($clog2(FRAME_LEN))'(FRAME_LEN - 1)) ?
                        '0 : slot_cnt + 1'b1;

            if (slot_cnt == '0) begin
               grp_cnt <= '0;
               if (faw_match) begin
                  miss_cnt       <= '0;
                  faw_boundary_o <= 1'b1;
               end else if (miss_cnt == 2'(FAW_MISS_LIMIT - 1)) begin
                  // Lock is released next cycle, nothing is strobed for this frame
                  drop_q <= 1'b1;
               end else begin
                  miss_cnt       <= miss_cnt + 1'b1;
                  faw_boundary_o <= 1'b1;
               end
            end else if (grp_cnt == 3'(GROUP_LEN - 1)) begin
               crc_boundary_o <= 1'b1;
               grp_cnt        <= '0;
            end else begin
               data_strobe_o <= 1'b1;
               group_pos_o   <= grp_cnt;
               grp_cnt       <= grp_cnt + 1'b1;
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- verilog/qeciphy_pkg.sv
// ----------------------------------------
// Frame geometry, CRC and lock definitions
// shared by the receive frame checker
// ----------------------------------------
`default_nettype none

package qeciphy_pkg;

   // Stream word width, one word per clock
   localparam int WORD_W = 64;

   // One FAW slot, then groups of six data words and one CRC word
   localparam int GROUP_LEN        = 7;
   localparam int GROUPS_PER_FRAME = 9;
   localparam int FRAME_LEN        = 1 + GROUPS_PER_FRAME * GROUP_LEN;

   // Word expected in slot 0 of every frame
   localparam logic [WORD_W-1:0] FAW_PATTERN = 64'h5A3C_F00F_C3A5_96E1;

   // Consecutive bad slot 0 words tolerated before alignment is given up
   localparam int FAW_MISS_LIMIT = 2;

   // CRC-16 over data word pairs, MSB first, no reflection, no final XOR
   localparam logic [15:0] CRC16_POLY = 16'h1021;
   localparam logic [15:0] CRC16_INIT = 16'hFFFF;

   // CRC-8 over the three CRC-16 results
   localparam logic [7:0] CRC8_POLY = 8'h07;
   localparam logic [7:0] CRC8_INIT = 8'h00;

   typedef enum logic {
      HUNT,
      LOCKED
   } lock_state_t;

endpackage

`default_nettype wire
